// ==== rtl/support_logic_settings.svh ====
/*
  Build-time limits shared by the support logic and its testbench.
  SL_MAX_OUTSTANDING must match what the core can actually issue per bus.
*/

`ifndef SUPPORT_LOGIC_SETTINGS_SVH
`define SUPPORT_LOGIC_SETTINGS_SVH

// --------------------
// OBI bus limits
// --------------------

// Requests in flight per bus, also the tag FIFO depth
`define SL_MAX_OUTSTANDING 2

// Outstanding count and event counter width
`define SL_CNT_W 8

// --------------------
// Interrupt causes
// --------------------

`define SL_CAUSE_W 11

// NMI-class causes, not counted as retired interrupts
`define SL_NMI_CAUSE_LO 1024
`define SL_NMI_CAUSE_HI 1027

`endif

// ==== rtl/support_logic_pkg.sv ====
/*
  Types shared by the OBI observers and the retire tracker.
*/

`default_nettype none

package support_logic_pkg;

  // Side information carried from grant to response
  typedef struct packed {
    logic integrity;
    logic gntpar_err;
  } resp_tag_t;

  // Recorded debug request window
  typedef enum logic [0:0] {
    DBG_REC_IDLE,
    DBG_REC_HOLD
  } dbg_rec_state_e;

  // Where the last retirement was relative to debug mode
  typedef enum logic [1:0] {
    DBG_OUT,
    DBG_IN,
    DBG_LEAVING
  } dbg_mode_state_e;

endpackage

`default_nettype wire

// ==== rtl/obi_phase_monitor.sv ====
/*
  Address-phase and outstanding-request tracking for one OBI bus.
  Assumes in-order responses arriving at least one cycle after the grant.
*/

`timescale 1ns/100ps
`default_nettype none

`include "support_logic_settings.svh"

module obi_phase_monitor (
  input  logic                 in_support_if,
  input  logic                 rst_n_i,
  input  logic                 bus_req_i,
  input  logic                 bus_gnt_i,
  input  logic                 bus_rvalid_i,
  output logic                 addr_ph_cont_o,
  output logic [`SL_CNT_W-1:0] outstanding_cnt_o
);

  logic                 accept;
  // Previous cycle held a request that was not granted
  logic                 req_wait_q;
  logic [`SL_CNT_W-1:0] cnt_q;

  assign accept = bus_req_i && bus_gnt_i;

  // Same request still waiting in its address phase
  assign addr_ph_cont_o = bus_req_i && req_wait_q;

  assign outstanding_cnt_o = cnt_q;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      req_wait_q <= 1'b0;
      cnt_q      <= '0;
    end else begin
      req_wait_q <= bus_req_i && !bus_gnt_i;
      // Accept and response in one cycle cancel out
      case ({accept, bus_rvalid_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // --------------------
  // Checks
  // --------------------

  // A response needs an earlier accepted request
  a_no_orphan_rvalid: assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    bus_rvalid_i |-> (outstanding_cnt_o != '0)
  ) else $error("rvalid with no request outstanding");

  a_cnt_limit: assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    outstanding_cnt_o <= `SL_MAX_OUTSTANDING
  ) else $error("more than %0d requests outstanding", `SL_MAX_OUTSTANDING);

endmodule

`default_nettype wire

// ==== rtl/resp_tag_fifo.sv ====
/*
  In-order store of response tags, written at grant, read at rvalid.
  Head is combinational; push and pop may share a cycle, even when full.
*/

`timescale 1ns/100ps
`default_nettype none

`include "support_logic_settings.svh"

module resp_tag_fifo
  import support_logic_pkg::*;
#(
  parameter int DEPTH = `SL_MAX_OUTSTANDING
) (
  input  logic      in_support_if,
  input  logic      rst_n_i,
  input  logic      push_i,
  input  logic      pop_i,
  input  resp_tag_t tag_i,
  output resp_tag_t resp_tag_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  resp_tag_t        mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] fill_q;
  logic             full;
  logic             empty;

  assign full  = (fill_q == CNT_W'(DEPTH));
  assign empty = (fill_q == '0);

  // Oldest outstanding request
  assign resp_tag_o = mem_q[rd_ptr_q];

  // Payload storage
  always_ff @(posedge in_support_if) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= tag_i;
    end
  end

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_i) begin
        if (wr_ptr_q == PTR_W'(DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop_i) begin
        if (rd_ptr_q == PTR_W'(DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      case ({push_i, pop_i})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  // --------------------
  // Checks
  // --------------------

  a_no_overflow: assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    (push_i && !pop_i) |-> !full
  ) else $error("tag pushed into full FIFO");

  a_no_underflow: assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    pop_i |-> !empty
  ) else $error("tag popped from empty FIFO");

endmodule

`default_nettype wire

// ==== rtl/obi_bus_observer.sv ====
/*
  Observes one OBI bus: phase tracking, grant-parity checking and a
  per-request tag returned with each response. Never drives the bus.
*/

`timescale 1ns/100ps
`default_nettype none

`include "support_logic_settings.svh"

module obi_bus_observer
  import support_logic_pkg::*;
(
  input  logic                 in_support_if,
  input  logic                 rst_n_i,
  input  logic                 bus_req_i,
  input  logic                 bus_gnt_i,
  input  logic                 bus_rvalid_i,
  input  logic                 bus_gntpar_i,
  input  logic                 req_integrity_i,
  output logic                 addr_ph_cont_o,
  output logic [`SL_CNT_W-1:0] outstanding_cnt_o,
  output resp_tag_t            resp_tag_o
);

  logic      accept;
  logic      gntpar_err;
  // Error seen earlier in the current unaccepted address phase
  logic      gntpar_err_q;
  resp_tag_t tag_in;

  assign accept = bus_req_i && bus_gnt_i;

  // gntpar should always be the inverse of gnt
  assign gntpar_err = bus_req_i && ((bus_gnt_i == bus_gntpar_i) || gntpar_err_q);

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      gntpar_err_q <= 1'b0;
    end else if (bus_req_i && !bus_gnt_i) begin
      gntpar_err_q <= gntpar_err;
    end else begin
      gntpar_err_q <= 1'b0;
    end
  end

  // Tag as it stands in the accepting cycle
  always_comb begin
    tag_in.integrity  = req_integrity_i;
    tag_in.gntpar_err = gntpar_err;
  end

  // --------------------
  // Submodules
  // --------------------

  obi_phase_monitor u_phase_monitor (
    .in_support_if     (in_support_if),
    .rst_n_i           (rst_n_i),
    .bus_req_i         (bus_req_i),
    .bus_gnt_i         (bus_gnt_i),
    .bus_rvalid_i      (bus_rvalid_i),
    .addr_ph_cont_o    (addr_ph_cont_o),
    .outstanding_cnt_o (outstanding_cnt_o)
  );

  resp_tag_fifo #(
    .DEPTH (`SL_MAX_OUTSTANDING)
  ) u_tag_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .push_i        (accept),
    .pop_i         (bus_rvalid_i),
    .tag_i         (tag_in),
    .resp_tag_o    (resp_tag_o)
  );

  // Parity is only meaningful during an address phase
  a_gntpar_known: assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    bus_req_i |-> !$isunknown(bus_gntpar_i)
  ) else $error("gntpar unknown while req is high");

endmodule

`default_nettype wire

// ==== rtl/retire_event_tracker.sv ====
/*
  Events derived from the retirement port: first fetch, first debug-mode
  retirement, a recorded debug request window and interrupt counters.
  Counters saturate at all ones and never wrap.
*/

`timescale 1ns/100ps
`default_nettype none

`include "support_logic_settings.svh"

module retire_event_tracker
  import support_logic_pkg::*;
(
  input  logic                   in_support_if,
  input  logic                   rst_n_i,
  input  logic                   rvfi_valid_i,
  input  logic                   rvfi_dbg_mode_i,
  input  logic                   rvfi_is_dret_i,
  input  logic                   rvfi_trap_i,
  input  logic                   rvfi_intr_i,
  input  logic [`SL_CAUSE_W-1:0] rvfi_intr_cause_i,
  input  logic                   debug_req_i,
  input  logic                   irq_ack_i,
  input  logic                   fetch_enable_i,
  output logic                   first_fetch_o,
  output logic                   first_debug_ins_o,
  output logic                   recorded_dbg_req_o,
  output logic [`SL_CNT_W-1:0]   cnt_irq_ack_o,
  output logic [`SL_CNT_W-1:0]   cnt_rvfi_irqs_o
);

  localparam logic [`SL_CAUSE_W-1:0] NMI_LO = `SL_CAUSE_W'(`SL_NMI_CAUSE_LO);
  localparam logic [`SL_CAUSE_W-1:0] NMI_HI = `SL_CAUSE_W'(`SL_NMI_CAUSE_HI);

  logic                 fetch_seen_q;
  dbg_mode_state_e      mode_state_q;
  dbg_rec_state_e       rec_state_q;
  // Retirements left before the recorded request drops
  logic [1:0]           rec_left_q;
  logic                 cause_is_nmi;
  logic                 count_rvfi_irq;
  logic [`SL_CNT_W-1:0] cnt_irq_ack_q;
  logic [`SL_CNT_W-1:0] cnt_rvfi_irqs_q;

  // --------------------
  // Startup
  // --------------------

  assign first_fetch_o = fetch_enable_i && !fetch_seen_q;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      fetch_seen_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_seen_q <= 1'b1;
    end
  end

  // --------------------
  // Debug mode entry
  // --------------------

  assign first_debug_ins_o = rvfi_valid_i && rvfi_dbg_mode_i && (mode_state_q != DBG_IN);

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      mode_state_q <= DBG_OUT;
    end else if (rvfi_valid_i) begin
      // A completed dret ends the debug session
      if (rvfi_is_dret_i && !rvfi_trap_i) begin
        mode_state_q <= DBG_LEAVING;
      end else if (rvfi_dbg_mode_i) begin
        mode_state_q <= DBG_IN;
      end else begin
        mode_state_q <= DBG_OUT;
      end
    end
  end

  // Recorded debug request
  // Held for two more retirements, or three if the request came between them
  assign recorded_dbg_req_o = (rec_state_q == DBG_REC_HOLD);

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      rec_state_q <= DBG_REC_IDLE;
      rec_left_q  <= 2'd0;
    end else if (debug_req_i) begin
      rec_state_q <= DBG_REC_HOLD;
      rec_left_q  <= rvfi_valid_i ? 2'd2 : 2'd3;
    end else if ((rec_state_q == DBG_REC_HOLD) && rvfi_valid_i) begin
      if (rec_left_q == 2'd1) begin
        rec_state_q <= DBG_REC_IDLE;
      end
      rec_left_q <= rec_left_q - 2'd1;
    end
  end

  // --------------------
  // Interrupt counters
  // --------------------

  assign cause_is_nmi   = (rvfi_intr_cause_i >= NMI_LO) && (rvfi_intr_cause_i <= NMI_HI);
  assign count_rvfi_irq = rvfi_valid_i && rvfi_intr_i && !cause_is_nmi;

  assign cnt_irq_ack_o   = cnt_irq_ack_q;
  assign cnt_rvfi_irqs_o = cnt_rvfi_irqs_q;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      cnt_irq_ack_q   <= '0;
      cnt_rvfi_irqs_q <= '0;
    end else begin
      if (irq_ack_i && (cnt_irq_ack_q != '1)) begin
        cnt_irq_ack_q <= cnt_irq_ack_q + 1'b1;
      end
      if (count_rvfi_irq && (cnt_rvfi_irqs_q != '1)) begin
        cnt_rvfi_irqs_q <= cnt_rvfi_irqs_q + 1'b1;
      end
    end
  end

  // --------------------
  // Checks
  // --------------------

  a_first_dbg_on_retire: assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    first_debug_ins_o |-> rvfi_valid_i
  ) else $error("first debug instruction flagged without retirement");

endmodule

`default_nettype wire

// ==== rtl/support_logic_top.sv ====
/*
  Passive support logic for a RISC-V core: two OBI bus observers and a
  retirement event tracker. All outputs are for assertions only.
*/

`timescale 1ns/100ps
`default_nettype none

`include "support_logic_settings.svh"

module support_logic_top
  import support_logic_pkg::*;
(
  input  logic                   in_support_if,
  input  logic                   rst_n_i,
  // Instruction bus
  input  logic                   instr_bus_req_i,
  input  logic                   instr_bus_gnt_i,
  input  logic                   instr_bus_rvalid_i,
  input  logic                   instr_bus_gntpar_i,
  input  logic                   instr_req_integrity_i,
  output logic                   instr_addr_ph_cont_o,
  output logic [`SL_CNT_W-1:0]   instr_outstanding_cnt_o,
  output resp_tag_t              instr_resp_tag_o,
  // Data bus
  input  logic                   data_bus_req_i,
  input  logic                   data_bus_gnt_i,
  input  logic                   data_bus_rvalid_i,
  input  logic                   data_bus_gntpar_i,
  input  logic                   data_req_integrity_i,
  output logic                   data_addr_ph_cont_o,
  output logic [`SL_CNT_W-1:0]   data_outstanding_cnt_o,
  output resp_tag_t              data_resp_tag_o,
  // Retirement port and core control
  input  logic                   rvfi_valid_i,
  input  logic                   rvfi_dbg_mode_i,
  input  logic                   rvfi_is_dret_i,
  input  logic                   rvfi_trap_i,
  input  logic                   rvfi_intr_i,
  input  logic [`SL_CAUSE_W-1:0] rvfi_intr_cause_i,
  input  logic                   debug_req_i,
  input  logic                   irq_ack_i,
  input  logic                   fetch_enable_i,
  output logic                   first_fetch_o,
  output logic                   first_debug_ins_o,
  output logic                   recorded_dbg_req_o,
  output logic [`SL_CNT_W-1:0]   cnt_irq_ack_o,
  output logic [`SL_CNT_W-1:0]   cnt_rvfi_irqs_o
);

  obi_bus_observer u_instr_obs (
    .in_support_if     (in_support_if),
    .rst_n_i           (rst_n_i),
    .bus_req_i         (instr_bus_req_i),
    .bus_gnt_i         (instr_bus_gnt_i),
    .bus_rvalid_i      (instr_bus_rvalid_i),
    .bus_gntpar_i      (instr_bus_gntpar_i),
    .req_integrity_i   (instr_req_integrity_i),
    .addr_ph_cont_o    (instr_addr_ph_cont_o),
    .outstanding_cnt_o (instr_outstanding_cnt_o),
    .resp_tag_o        (instr_resp_tag_o)
  );

  obi_bus_observer u_data_obs (
    .in_support_if     (in_support_if),
    .rst_n_i           (rst_n_i),
    .bus_req_i         (data_bus_req_i),
    .bus_gnt_i         (data_bus_gnt_i),
    .bus_rvalid_i      (data_bus_rvalid_i),
    .bus_gntpar_i      (data_bus_gntpar_i),
    .req_integrity_i   (data_req_integrity_i),
    .addr_ph_cont_o    (data_addr_ph_cont_o),
    .outstanding_cnt_o (data_outstanding_cnt_o),
    .resp_tag_o        (data_resp_tag_o)
  );

  retire_event_tracker u_retire (
    .in_support_if      (in_support_if),
    .rst_n_i            (rst_n_i),
    .rvfi_valid_i       (rvfi_valid_i),
    .rvfi_dbg_mode_i    (rvfi_dbg_mode_i),
    .rvfi_is_dret_i     (rvfi_is_dret_i),
    .rvfi_trap_i        (rvfi_trap_i),
    .rvfi_intr_i        (rvfi_intr_i),
    .rvfi_intr_cause_i  (rvfi_intr_cause_i),
    .debug_req_i        (debug_req_i),
    .irq_ack_i          (irq_ack_i),
    .fetch_enable_i     (fetch_enable_i),
    .first_fetch_o      (first_fetch_o),
    .first_debug_ins_o  (first_debug_ins_o),
    .recorded_dbg_req_o (recorded_dbg_req_o),
    .cnt_irq_ack_o      (cnt_irq_ack_o),
    .cnt_rvfi_irqs_o    (cnt_rvfi_irqs_o)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
/*
  Testbench clock and reset. 20 ns period, reset held low for two
  rising edges and released on a falling edge.
*/

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== dv/tb_support_logic.sv ====
/*
  Testbench for support_logic_top. Reference models run beside the DUT and
  concurrent assertions compare them. Index 0 is the instr bus, 1 the data bus.
*/

`timescale 1ns/100ps
`default_nettype none

`include "support_logic_settings.svh"

module tb_support_logic
  import support_logic_pkg::*;
;

  logic clk;
  logic rst_n;
  logic [1:0] req, gnt, rvalid, gntpar, integ;
  // Request in its address phase had a spoiled gntpar
  logic [1:0] exp_perr;
  logic [1:0] addr_cont;
  logic [`SL_CNT_W-1:0] out_cnt [2];
  resp_tag_t resp_tag [2];
  logic rvfi_valid, rvfi_dbg, rvfi_dret, rvfi_trap, rvfi_intr;
  logic [`SL_CAUSE_W-1:0] rvfi_cause;
  logic debug_req, irq_ack, fetch_en;
  logic first_fetch, first_dbg, rec_dbg;
  logic [`SL_CNT_W-1:0] cnt_ack, cnt_irqs;
  int errors = 0;
  int tests = 0;
  logic [31:0] seed = 32'h7c4c0d4f;

  tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

  support_logic_top DUT (
    .in_support_if (clk), .rst_n_i (rst_n),
    .instr_bus_req_i (req[0]), .instr_bus_gnt_i (gnt[0]),
    .instr_bus_rvalid_i (rvalid[0]), .instr_bus_gntpar_i (gntpar[0]),
    .instr_req_integrity_i (integ[0]), .instr_addr_ph_cont_o (addr_cont[0]),
    .instr_outstanding_cnt_o (out_cnt[0]), .instr_resp_tag_o (resp_tag[0]),
    .data_bus_req_i (req[1]), .data_bus_gnt_i (gnt[1]),
    .data_bus_rvalid_i (rvalid[1]), .data_bus_gntpar_i (gntpar[1]),
    .data_req_integrity_i (integ[1]), .data_addr_ph_cont_o (addr_cont[1]),
    .data_outstanding_cnt_o (out_cnt[1]), .data_resp_tag_o (resp_tag[1]),
    .rvfi_valid_i (rvfi_valid), .rvfi_dbg_mode_i (rvfi_dbg),
    .rvfi_is_dret_i (rvfi_dret), .rvfi_trap_i (rvfi_trap),
    .rvfi_intr_i (rvfi_intr), .rvfi_intr_cause_i (rvfi_cause),
    .debug_req_i (debug_req), .irq_ack_i (irq_ack), .fetch_enable_i (fetch_en),
    .first_fetch_o (first_fetch), .first_debug_ins_o (first_dbg),
    .recorded_dbg_req_o (rec_dbg), .cnt_irq_ack_o (cnt_ack),
    .cnt_rvfi_irqs_o (cnt_irqs)
  );

  // --------------------
  // OBI reference models
  // --------------------

  for (genvar b = 0; b < 2; b++) begin : g_bus
    resp_tag_t            model_q [$];
    resp_tag_t            exp_tag;
    resp_tag_t            head_q;
    logic                 wait_q;
    logic [`SL_CNT_W-1:0] cnt_q;

    // Expected tag at acceptance as set up by the stimulus
    assign exp_tag = '{integrity: integ[b], gntpar_err: exp_perr[b]};

    always @(posedge clk) begin
      if (!rst_n) begin
        model_q.delete();
        wait_q <= 1'b0;
        head_q <= '0;
        cnt_q  <= '0;
      end else begin
        if (rvalid[b] && (model_q.size() > 0)) void'(model_q.pop_front());
        if (req[b] && gnt[b]) model_q.push_back(exp_tag);
        wait_q <= req[b] && !gnt[b];
        head_q <= (model_q.size() > 0) ? model_q[0] : '0;
        cnt_q  <= `SL_CNT_W'(model_q.size());
      end
    end

    a_addr_ph: assert property (@(posedge clk) disable iff (!rst_n)
      addr_cont[b] == (req[b] && wait_q)) else begin
      errors++;
      $display("FAILED %0t: bus %0d addr_ph_cont_o is %b", $time, b, addr_cont[b]);
    end

    a_out_cnt: assert property (@(posedge clk) disable iff (!rst_n)
      out_cnt[b] == cnt_q) else begin
      errors++;
      $display("FAILED %0t: bus %0d outstanding %0d, expected %0d",
               $time, b, out_cnt[b], cnt_q);
    end

    a_resp_tag: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid[b] |-> (resp_tag[b] == head_q)) else begin
      errors++;
      $display("FAILED %0t: bus %0d tag %b, expected %b", $time, b, resp_tag[b], head_q);
    end
  end

  // --------------------
  // Retire reference model
  // --------------------

  logic                 m_fetch_seen, m_prev_dbg, m_dret_done;
  logic [1:0]           m_rec_left;
  logic [`SL_CNT_W-1:0] m_ack, m_irqs;
  logic                 m_nmi;

  assign m_nmi = (rvfi_cause >= `SL_NMI_CAUSE_LO) && (rvfi_cause <= `SL_NMI_CAUSE_HI);

  always @(posedge clk) begin
    if (!rst_n) begin
      m_fetch_seen <= 1'b0;
      m_prev_dbg   <= 1'b0;
      m_dret_done  <= 1'b0;
      m_rec_left   <= 2'd0;
      m_ack        <= '0;
      m_irqs       <= '0;
    end else begin
      if (fetch_en) m_fetch_seen <= 1'b1;
      if (rvfi_valid) begin
        m_prev_dbg  <= rvfi_dbg;
        m_dret_done <= rvfi_dret && !rvfi_trap;
      end
      if (debug_req) m_rec_left <= rvfi_valid ? 2'd2 : 2'd3;
      else if (rvfi_valid && (m_rec_left != 0)) m_rec_left <= m_rec_left - 2'd1;
      if (irq_ack && (m_ack != '1)) m_ack <= m_ack + 1'b1;
      if (rvfi_valid && rvfi_intr && !m_nmi && (m_irqs != '1)) m_irqs <= m_irqs + 1'b1;
    end
  end

  a_first_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    first_fetch == (fetch_en && !m_fetch_seen)) else begin
    errors++;
    $display("FAILED %0t: first_fetch_o is %b", $time, first_fetch);
  end

  a_first_dbg: assert property (@(posedge clk) disable iff (!rst_n)
    first_dbg == (rvfi_valid && rvfi_dbg && (!m_prev_dbg || m_dret_done))) else begin
    errors++;
    $display("FAILED %0t: first_debug_ins_o is %b", $time, first_dbg);
  end

  a_rec_dbg: assert property (@(posedge clk) disable iff (!rst_n)
    rec_dbg == (m_rec_left != 0)) else begin
    errors++;
    $display("FAILED %0t: recorded_dbg_req_o is %b", $time, rec_dbg);
  end

  a_counters: assert property (@(posedge clk) disable iff (!rst_n)
    (cnt_ack == m_ack) && (cnt_irqs == m_irqs)) else begin
    errors++;
    $display("FAILED %0t: counters %0d/%0d, expected %0d/%0d",
             $time, cnt_ack, cnt_irqs, m_ack, m_irqs);
  end

  // --------------------
  // Stimulus helpers
  // --------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int random_waits();
    seed = lcg_next(seed);
    return int'(seed[17:16]);
  endfunction

  // One request; wait cycle number bad_at carries a wrong gntpar
  task automatic obi_request(input int b, input logic integrity, input int waits,
                             input int bad_at);
    req[b]      = 1'b1;
    integ[b]    = integrity;
    exp_perr[b] = (bad_at >= 0) && (bad_at < waits);
    for (int i = 0; i < waits; i++) begin
      gnt[b]    = 1'b0;
      gntpar[b] = (i == bad_at) ? 1'b0 : 1'b1;
      @(negedge clk);
    end
    gnt[b]    = 1'b1;
    gntpar[b] = 1'b0;
    @(negedge clk);
    req[b]      = 1'b0;
    gnt[b]      = 1'b0;
    gntpar[b]   = 1'b1;
    integ[b]    = 1'b0;
    exp_perr[b] = 1'b0;
  endtask

  task automatic obi_response(input int b);
    rvalid[b] = 1'b1;
    @(negedge clk);
    rvalid[b] = 1'b0;
  endtask

  task automatic wait_outstanding(input int b, input int target);
    int i;
    for (i = 0; (i < 20) && (out_cnt[b] != `SL_CNT_W'(target)); i++) @(negedge clk);
    if (out_cnt[b] != `SL_CNT_W'(target)) begin
      errors++;
      $display("Timed out: bus %0d never reached %0d outstanding requests", b, target);
    end
  endtask

  task automatic retire(input logic dbg, input logic dret, input logic intr,
                        input int cause);
    rvfi_valid = 1'b1;
    rvfi_dbg   = dbg;
    rvfi_dret  = dret;
    rvfi_intr  = intr;
    rvfi_cause = `SL_CAUSE_W'(cause);
    @(negedge clk);
    {rvfi_valid, rvfi_dbg, rvfi_dret, rvfi_intr} = '0;
    @(negedge clk);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d (%s) finished, %0d errors so far", tests, name, errors);
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    int i;
    {req, gnt, rvalid, integ} = '0;
    gntpar = 2'b11;
    exp_perr = '0;
    {rvfi_valid, rvfi_dbg, rvfi_dret, rvfi_trap, rvfi_intr} = '0;
    rvfi_cause = '0;
    {debug_req, irq_ack, fetch_en} = '0;
    for (i = 0; (i < 10) && (rst_n !== 1'b1); i++) @(negedge clk);
    if (rst_n !== 1'b1) begin
      errors++;
      $display("Timed out: reset was never released");
    end
    @(negedge clk);

    for (int b = 0; b < 2; b++) begin
      obi_request(b, 1'b0, random_waits(), -1);
      wait_outstanding(b, 1);
      obi_request(b, 1'b0, random_waits(), -1);
      wait_outstanding(b, 2);
      obi_response(b);
      obi_response(b);
      wait_outstanding(b, 0);
    end
    end_test("address phase");

    for (int b = 0; b < 2; b++) begin
      obi_request(b, 1'b1, random_waits(), -1);
      obi_request(b, 1'b0, random_waits(), -1);
      wait_outstanding(b, 2);
      obi_response(b);
      obi_response(b);
      wait_outstanding(b, 0);
    end
    end_test("tags in order");

    obi_request(0, 1'b0, 3, 0);
    obi_request(0, 1'b1, 2, -1);
    wait_outstanding(0, 2);
    obi_response(0);
    obi_response(0);
    wait_outstanding(0, 0);
    end_test("grant parity");

    retire(1'b0, 1'b0, 1'b0, 0);
    retire(1'b1, 1'b0, 1'b0, 0);
    retire(1'b1, 1'b0, 1'b0, 0);
    retire(1'b1, 1'b1, 1'b0, 0);
    retire(1'b1, 1'b0, 1'b0, 0);
    // A trapping dret stays in debug mode
    rvfi_trap = 1'b1;
    retire(1'b1, 1'b1, 1'b0, 0);
    rvfi_trap = 1'b0;
    retire(1'b1, 1'b0, 1'b0, 0);
    retire(1'b0, 1'b0, 1'b0, 0);
    debug_req = 1'b1;
    @(negedge clk);
    debug_req = 1'b0;
    repeat (4) retire(1'b0, 1'b0, 1'b0, 0);
    // Request in a retiring cycle
    debug_req  = 1'b1;
    rvfi_valid = 1'b1;
    @(negedge clk);
    debug_req  = 1'b0;
    rvfi_valid = 1'b0;
    @(negedge clk);
    repeat (3) retire(1'b0, 1'b0, 1'b0, 0);
    end_test("debug");

    fetch_en = 1'b1;
    repeat (3) @(negedge clk);
    fetch_en = 1'b0;
    @(negedge clk);
    fetch_en = 1'b1;
    for (int k = 0; k < 3; k++) begin
      irq_ack = 1'b1;
      @(negedge clk);
      irq_ack = 1'b0;
      @(negedge clk);
    end
    retire(1'b0, 1'b0, 1'b1, 3);
    retire(1'b0, 1'b0, 1'b1, 1024);
    retire(1'b0, 1'b0, 1'b1, 1027);
    retire(1'b0, 1'b0, 1'b1, 1028);
    retire(1'b0, 1'b0, 1'b1, 11);
    end_test("startup and interrupts");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== support_logic.f ====
+incdir+rtl
rtl/support_logic_pkg.sv
rtl/obi_phase_monitor.sv
rtl/resp_tag_fifo.sv
rtl/obi_bus_observer.sv
rtl/retire_event_tracker.sv
rtl/support_logic_top.sv
dv/tb_clock_gen.sv
dv/tb_support_logic.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_support_logic
RTL_TOP   ?= support_logic_top
FILELIST  ?= support_logic.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "sim passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
